//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_execute
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILE_LIST) | grep -v '^+')
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
+incdir+verilog
verilog/core_pkg.sv
verilog/regfile_if.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/stage_reg.sv
verilog/hazard_unit.sv
verilog/int_alu.sv
verilog/decode_execute_top.sv
testbench/decode_execute_chk.sv
testbench/tb_decode_execute.sv

//--- testbench/decode_execute_chk.sv
`timescale 1ns/100ps
`default_nettype none

module decode_execute_chk (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic id_write,
    input logic wb_valid
);

    // EX/WB comes out of reset empty
    reset_empty: assert property (@(posedge clk) $past(rst) |-> !wb_valid)
        else $error("wb_valid high on the edge after reset");

    // A stall edge drains EX/WB
    stall_bubble: assert property (@(posedge clk) disable iff (rst) $past(stall) |-> !wb_valid)
        else $error("wb_valid high after a stall edge");

    // Accepted, then one edge without stall, then on the result ports
    two_edge_latency: assert property (@(posedge clk) disable iff (rst)
        ($past(id_write && !stall, 2) && !$past(stall)) |-> wb_valid)
        else $error("accepted instruction missing two edges later");

endmodule

bind decode_execute_top decode_execute_chk u_decode_execute_chk (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .id_write (id_payload.reg_write),
    .wb_valid (wb_valid)
);

`default_nettype wire

//--- testbench/tb_decode_execute.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode_execute;

    localparam int PERIOD = 40;
    localparam int NUM_INSTR = 200;
    localparam int SEED_COUNT = 8;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [63:0] pc;
    logic        instr_valid;
    logic        stall;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [63:0] wb_result;

    logic [15:0] lfsr_state = 16'd22;
    logic [63:0] model_regs [32];
    logic [68:0] exp_q [$];
    logic [68:0] head;
    logic [31:0] pend_word;
    logic [63:0] pend_pc;
    bit          has_pend;
    bit          id_busy;
    bit          wb_busy;
    bit          take_valid;
    bit          take_stall;
    int          issued;
    int          seen;
    int          error_count;

    decode_execute_top u_decode_execute_top (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .stall       (stall),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_result   (wb_result)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Encode one instruction, work out its result and queue it
    task automatic make_instr(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [19:0] ib);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] imm_u;
        logic [63:0] res;
        logic [31:0] w;
        a = model_regs[rs1];
        b = model_regs[rs2];
        imm_i = {{52{ib[11]}}, ib[11:0]};
        imm_u = {{32{ib[19]}}, ib, 12'b0};
        case (kind)
            0: w = {7'h00, rs2, rs1, 3'd0, rd, 7'h33};
            1: w = {7'h20, rs2, rs1, 3'd0, rd, 7'h33};
            2: w = {7'h00, rs2, rs1, 3'd7, rd, 7'h33};
            3: w = {7'h00, rs2, rs1, 3'd6, rd, 7'h33};
            4: w = {7'h00, rs2, rs1, 3'd4, rd, 7'h33};
            5: w = {7'h00, rs2, rs1, 3'd2, rd, 7'h33};
            6: w = {7'h00, rs2, rs1, 3'd1, rd, 7'h33};
            7: w = {7'h00, rs2, rs1, 3'd5, rd, 7'h33};
            8: w = {ib[11:0], rs1, 3'd0, rd, 7'h13};
            9: w = {ib[11:0], rs1, 3'd7, rd, 7'h13};
            10: w = {ib[11:0], rs1, 3'd6, rd, 7'h13};
            11: w = {ib[11:0], rs1, 3'd4, rd, 7'h13};
            12: w = {ib, rd, 7'h37};
            13: w = {ib, rd, 7'h17};
            14: w = {ib, rd, 7'h6f};
            default: w = {ib[11:0], rs1, 3'd0, rd, 7'h67};
        endcase
        // JAL and JALR share the link value
        case (kind)
            0: res = a + b;
            1: res = a - b;
            2: res = a & b;
            3: res = a | b;
            4: res = a ^ b;
            5: res = {63'd0, $signed(a) < $signed(b)};
            6: res = a << b[5:0];
            7: res = a >> b[5:0];
            8: res = a + imm_i;
            9: res = a & imm_i;
            10: res = a | imm_i;
            11: res = a ^ imm_i;
            12: res = imm_u;
            13: res = pend_pc + imm_u;
            default: res = pend_pc + 64'd4;
        endcase
        // x0 stays zero whatever is written to it
        if (rd != 5'd0) model_regs[rd] = res;
        exp_q.push_back({rd, res});
        pend_word = w;
    endtask

    task automatic report_mismatch(input logic [68:0] e);
        error_count++;
        $display("FAILED at %0t: rd %0d result %h, expected rd %0d result %h",
                 $time, wb_rd, wb_result, e[68:64], e[63:0]);
        $display("TEST FAIL");
        $fatal(1, "result mismatch");
    endtask

    always @(negedge clk) begin
        if (!rst && wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("A result came out with no instruction waiting for it at %0t", $time);
                $display("TEST FAIL");
                $fatal(1, "extra result");
            end else begin
                head = exp_q.pop_front();
                assert (wb_rd == head[68:64] && wb_result == head[63:0])
                    else report_mismatch(head);
                seen++;
            end
        end
    end

    initial begin
        #(longint'(NUM_INSTR) * 4 * PERIOD + 100 * PERIOD);
        $display("timeout: results stopped arriving");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst = 1'b1;
        instr = '0;
        pc = '0;
        instr_valid = 1'b0;
        stall = 1'b0;
        pend_pc = 64'h0000_0000_8000_0000;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (issued < NUM_INSTR) begin
            @(posedge clk);
            // What ID/EX and EX/WB hold after this edge
            if (stall) begin
                wb_busy = 1'b0;
            end else begin
                wb_busy = id_busy;
                id_busy = instr_valid;
            end
            take_valid = (issued < SEED_COUNT) || (take_bits(3) != 0);
            // A held instruction must keep its EX/WB forwarding source
            take_stall = !(id_busy && wb_busy) && issued >= SEED_COUNT &&
                         take_bits(3) == 0;
            if (take_valid && !has_pend) begin
                pend_pc = pend_pc + 64'd4;
                if (issued < SEED_COUNT) begin
                    make_instr(8, 5'(issued + 1), 5'd0, 5'd0, 20'(issued * 83 + 5));
                end else begin
                    make_instr(int'(take_bits(4)), 5'(take_bits(5)), 5'(take_bits(5)),
                               5'(take_bits(5)), 20'(take_bits(20)));
                end
                has_pend = 1'b1;
            end
            instr_valid <= take_valid;
            stall <= take_stall;
            if (take_valid) begin
                instr <= pend_word;
                pc <= pend_pc;
            end
            if (take_valid && !take_stall) begin
                has_pend = 1'b0;
                issued++;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        stall <= 1'b0;
        while (seen < NUM_INSTR) @(posedge clk);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/core_pkg.sv
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    // Major opcodes handled by this slice
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8,
        ALU_LINK   = 4'd9
    } alu_op_t;

    // FROM_WRITE kept for a later write-port bypass
    typedef enum logic [1:0] {
        FWD_REGFILE    = 2'd0,
        FWD_FROM_WB    = 2'd1,
        FWD_FROM_WRITE = 2'd2
    } fwd_sel_t;

    // ID/EX payload, all-zero is a bubble
    typedef struct packed {
        logic                  reg_write;
        logic                  alu_src;
        logic                  u_src;
        logic                  uj_src;
        logic                  jalr_src;
        alu_op_t               alu_op;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      read_data1;
        logic [`XLEN-1:0]      read_data2;
        logic [`XLEN-1:0]      imm;
        logic [`XLEN-1:0]      pc;
        logic [`ILEN-1:0]      instr;
    } id_ex_t;

    // EX/WB payload
    typedef struct packed {
        logic                  reg_write;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      result;
    } ex_wb_t;

endpackage

`default_nettype wire

//--- verilog/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Integer data path width, RV64
`define XLEN 64

// Fetched instruction width
`define ILEN 32

// Architectural register index
`define REG_IDX_W 5

// x0 through x31
`define REG_COUNT 32

`endif

//--- verilog/decode_execute_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module decode_execute_top
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ILEN-1:0]      instr,
    input  logic [`XLEN-1:0]      pc,
    input  logic                  instr_valid,
    input  logic                  stall,
    output logic                  wb_valid,
    output logic [`REG_IDX_W-1:0] wb_rd,
    output logic [`XLEN-1:0]      wb_result
);

    regfile_if rf_bus ();

    id_ex_t   id_payload;
    id_ex_t   ex_payload;
    ex_wb_t   ex_result;
    ex_wb_t   wb_payload;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     id_ex_hold;
    logic     id_ex_bubble;
    logic     ex_wb_bubble;

    instr_decoder u_instr_decoder (
        .instr       (instr),
        .pc          (pc),
        .instr_valid (instr_valid),
        .rf          (rf_bus),
        .id_out      (id_payload)
    );

    reg_file u_reg_file (
        .clk (clk),
        .rst (rst),
        .rf  (rf_bus)
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk    (clk),
        .rst    (rst),
        .hold   (id_ex_hold),
        .bubble (id_ex_bubble),
        .d      (id_payload),
        .q      (ex_payload)
    );

    hazard_unit u_hazard_unit (
        .stall        (stall),
        .instr_valid  (instr_valid),
        .ex_rs1       (ex_payload.rs1),
        .ex_rs2       (ex_payload.rs2),
        .wb_rd        (wb_payload.rd),
        .wb_reg_write (wb_payload.reg_write),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .id_ex_hold   (id_ex_hold),
        .id_ex_bubble (id_ex_bubble),
        .ex_wb_bubble (ex_wb_bubble)
    );

    int_alu u_int_alu (
        .ex_in     (ex_payload),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .wb_result (wb_payload.result),
        .ex_out    (ex_result)
    );

    // EX/WB never holds, a stall drains it instead
    stage_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (ex_wb_bubble),
        .d      (ex_result),
        .q      (wb_payload)
    );

    // Write-back port of the register file
    assign rf_bus.we    = wb_payload.reg_write;
    assign rf_bus.waddr = wb_payload.rd;
    assign rf_bus.wdata = wb_payload.result;

    assign wb_valid  = wb_payload.reg_write;
    assign wb_rd     = wb_payload.rd;
    assign wb_result = wb_payload.result;

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module hazard_unit
    import core_pkg::*;
(
    input  logic                  stall,
    input  logic                  instr_valid,
    input  logic [`REG_IDX_W-1:0] ex_rs1,
    input  logic [`REG_IDX_W-1:0] ex_rs2,
    input  logic [`REG_IDX_W-1:0] wb_rd,
    input  logic                  wb_reg_write,
    output fwd_sel_t              fwd_a,
    output fwd_sel_t              fwd_b,
    output logic                  id_ex_hold,
    output logic                  id_ex_bubble,
    output logic                  ex_wb_bubble
);

    logic wb_live;

    // EX/WB result that will land in the register file
    assign wb_live = wb_reg_write && (wb_rd != '0);

    assign fwd_a = (wb_live && wb_rd == ex_rs1) ? FWD_FROM_WB : FWD_REGFILE;
    assign fwd_b = (wb_live && wb_rd == ex_rs2) ? FWD_FROM_WB : FWD_REGFILE;

    // Stall freezes ID/EX and drains EX/WB
    assign id_ex_hold   = stall;
    assign ex_wb_bubble = stall;

    // Nothing to accept from fetch
    assign id_ex_bubble = !stall && !instr_valid;

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module instr_decoder
    import core_pkg::*;
(
    input  logic [`ILEN-1:0] instr,
    input  logic [`XLEN-1:0] pc,
    input  logic             instr_valid,
    regfile_if.decode        rf,
    output id_ex_t           id_out
);

    opcode_t          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic             supported;
    alu_op_t          alu_op;
    logic             alu_src;
    logic             u_src;
    logic             uj_src;
    logic             jalr_src;
    logic [`XLEN-1:0] imm;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Register file read addresses straight from the encoding
    assign rf.rs1 = instr[19:15];
    assign rf.rs2 = instr[24:20];

    // Sign-extended immediates
    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        supported = 1'b1;
        alu_op    = ALU_ADD;
        alu_src   = 1'b0;
        u_src     = 1'b0;
        uj_src    = 1'b0;
        jalr_src  = 1'b0;
        imm       = imm_i;
        case (opcode)
            OPC_OP: begin
                supported = (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0100000) begin
                            supported = 1'b1;
                            alu_op    = ALU_SUB;
                        end
                    end
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: alu_op = ALU_SRL;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                alu_src = 1'b1;
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                alu_src = 1'b1;
                u_src   = 1'b1;
                imm     = imm_u;
            end
            OPC_AUIPC: begin
                // pc plus the upper immediate
                alu_src = 1'b1;
                u_src   = 1'b1;
                imm     = imm_u;
            end
            OPC_JAL: begin
                alu_op = ALU_LINK;
                uj_src = 1'b1;
                imm    = imm_j;
            end
            OPC_JALR: begin
                alu_op   = ALU_LINK;
                jalr_src = 1'b1;
            end
            default: supported = 1'b0;
        endcase
    end

    always_comb begin
        id_out.reg_write  = instr_valid && supported;
        id_out.alu_src    = alu_src;
        id_out.u_src      = u_src;
        id_out.uj_src     = uj_src;
        id_out.jalr_src   = jalr_src;
        id_out.alu_op     = alu_op;
        id_out.rs1        = instr[19:15];
        id_out.rs2        = instr[24:20];
        id_out.rd         = instr[11:7];
        id_out.read_data1 = rf.rdata1;
        id_out.read_data2 = rf.rdata2;
        id_out.imm        = imm;
        id_out.pc         = pc;
        id_out.instr      = instr;
    end

endmodule

`default_nettype wire

//--- verilog/int_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module int_alu
    import core_pkg::*;
(
    input  id_ex_t           ex_in,
    input  fwd_sel_t         fwd_a,
    input  fwd_sel_t         fwd_b,
    input  logic [`XLEN-1:0] wb_result,
    output ex_wb_t           ex_out
);

    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [5:0]       shamt;
    logic             less;
    logic [`XLEN-1:0] result;

    // Forwarded register values
    assign src1 = (fwd_a == FWD_FROM_WB) ? wb_result : ex_in.read_data1;
    assign src2 = (fwd_b == FWD_FROM_WB) ? wb_result : ex_in.read_data2;

    // AUIPC takes pc as operand A
    assign op_a  = ex_in.u_src ? ex_in.pc : src1;
    assign op_b  = ex_in.alu_src ? ex_in.imm : src2;
    assign shamt = op_b[5:0];
    assign less  = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (ex_in.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, less};
            ALU_SLL:    result = op_a << shamt;
            ALU_SRL:    result = op_a >> shamt;
            ALU_PASS_B: result = op_b;
            // Return address for JAL and JALR
            ALU_LINK:   result = ex_in.pc + `XLEN'd4;
            default:    result = '0;
        endcase
    end

    assign ex_out.reg_write = ex_in.reg_write;
    assign ex_out.rd        = ex_in.rd;
    assign ex_out.result    = result;

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module reg_file (
    input  logic    clk,
    input  logic    rst,
    regfile_if.regs rf
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wr_live;

    // x0 is never written
    assign wr_live = rf.we && (rf.waddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // Same-cycle write is bypassed to the readers
    always_comb begin
        if (rf.rs1 == '0) begin
            rf.rdata1 = '0;
        end else if (wr_live && rf.waddr == rf.rs1) begin
            rf.rdata1 = rf.wdata;
        end else begin
            rf.rdata1 = regs[rf.rs1];
        end
        if (rf.rs2 == '0) begin
            rf.rdata2 = '0;
        end else if (wr_live && rf.waddr == rf.rs2) begin
            rf.rdata2 = rf.wdata;
        end else begin
            rf.rdata2 = regs[rf.rs2];
        end
    end

endmodule

`default_nettype wire

//--- verilog/regfile_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

interface regfile_if;

    // Read side, driven from decode
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`XLEN-1:0]      rdata1;
    logic [`XLEN-1:0]      rdata2;

    // Write side, driven from EX/WB
    logic                  we;
    logic [`REG_IDX_W-1:0] waddr;
    logic [`XLEN-1:0]      wdata;

    modport decode (output rs1, rs2, input rdata1, rdata2);
    modport writeback (output we, waddr, wdata);
    modport regs (input rs1, rs2, we, waddr, wdata, output rdata1, rdata2);

endinterface

`default_nettype wire

//--- verilog/stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // An all-zero payload carries reg_write low
    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire
